// File: verilog.f
verilog/cpuPkg.sv
verilog/microSequencer.sv
verilog/aluExecute.sv
verilog/writeBack.sv
verilog/wbMaster.sv
verilog/cpu.sv
bench/wbMemModel.sv
bench/cpuBench.sv

// File: Makefile
# Verilator build and run for the cpu testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run cpuBench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module cpuBench -o cpuBench
	./obj_dir/cpuBench | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

// File: bench/cpuBench.sv
`default_nettype none

module cpuBench;

    localparam int MAX_WAIT = 7;
    localparam int INSTR_TOTAL = 120;  // rough count over all programs

    logic          clk = 1'b0;
    logic          reset = 1'b1;
    logic          wbCyc;
    logic          wbStb;
    logic          wbWe;
    logic          wbAck;
    logic          outValid;
    logic          halted;
    logic [3:0]    maxWait = 4'd0;
    cpuPkg::addr_t wbAdr;
    cpuPkg::word_t wbDatOut;
    cpuPkg::word_t wbDatIn;
    cpuPkg::word_t outData;
    cpuPkg::word_t outQ [$];
    int            errors = 0;
    int            testsRun = 0;
    int            testsFailed = 0;

    always #4 clk = ~clk;

    cpu dut (.clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatOut(wbDatOut), .wbDatIn(wbDatIn), .wbAck(wbAck),
        .outData(outData), .outValid(outValid), .halted(halted));

    wbMemModel mem (.clk(clk), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatOut), .wbDatR(wbDatIn), .wbAck(wbAck), .maxWait(maxWait));

    always @(posedge clk) begin
        if (!reset && outValid) outQ.push_back(outData);
    end

    initial begin
        #(8 * 200 * INSTR_TOTAL * MAX_WAIT);
        $display("watchdog expired, the cpu stopped making progress");
        $display(">>> FAIL");
        $finish;
    end

    task automatic checkWord(input string name, input cpuPkg::word_t got,
                             input cpuPkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlagBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input cpuPkg::addr_t got,
                             input cpuPkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input int n);
        if (outQ.size() != n) begin
            errors++;
            $display("wrong number of OUT words at %0t: got %0d, expected %0d",
                $time, outQ.size(), n);
        end
    endtask

    function automatic cpuPkg::word_t aluWord(input cpuPkg::aluFn_t fn, input logic dx,
                                              input logic dy, input logic ce);
        cpuPkg::instr_t i;
        i = '0;
        i.aluView.opcode = cpuPkg::OP_ALU;
        i.aluView.fn = fn;
        i.aluView.destX = dx;
        i.aluView.destY = dy;
        i.aluView.carryEn = ce;
        return i;
    endfunction

    function automatic cpuPkg::word_t addrWord(input logic [3:0] op, input cpuPkg::addr_t a);
        cpuPkg::instr_t i;
        i.addrView.opcode = op;
        i.addrView.target = a;
        return i;
    endfunction

    task automatic runProgram(input logic [3:0] waits);
        reset <= 1'b1;
        maxWait <= waits;
        repeat (10) @(posedge clk);
        outQ.delete();
        reset <= 1'b0;
        @(posedge clk);
        while (!halted) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic report(input string name, input int errBefore);
        testsRun++;
        if (errors != errBefore) testsFailed++;
        $display("%s: %s", name, (errors == errBefore) ? "ok" : "failed");
    endtask

    task automatic checkIdle();
        checkFlagBit("wbCyc", wbCyc, 1'b0);
        checkFlagBit("wbStb", wbStb, 1'b0);
        checkFlagBit("wbWe", wbWe, 1'b0);
        checkFlagBit("outValid", outValid, 1'b0);
        checkFlagBit("halted", halted, 1'b0);
    endtask

    task automatic resetTest();
        int e0;
        e0 = errors;
        mem.fillPattern();
        mem.loadWord(12'd0, addrWord(cpuPkg::OP_HALT, 12'd0));
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        repeat (8) begin
            @(posedge clk);
            checkIdle();
        end
        reset <= 1'b0;
        @(posedge clk);
        checkIdle();    // just after reset falls
        while (!wbStb) @(posedge clk);
        checkAddr("wbAdr", wbAdr, 12'd0);
        checkFlagBit("wbWe", wbWe, 1'b0);   // first cycle is a read
        while (!halted) @(posedge clk);
        report("reset state", e0);
    endtask

    task automatic aluTest();
        cpuPkg::aluFn_t fns [6];
        cpuPkg::word_t  exp [6];
        cpuPkg::word_t  x;
        cpuPkg::word_t  y;
        cpuPkg::addr_t  pc;
        int             e0;
        e0 = errors;
        x = 16'($urandom);
        y = 16'($urandom);
        fns = '{6'b000010, 6'b000000, 6'b010011, 6'b001101, 6'b101010, 6'b111010};
        exp = '{x + y, x & y, x - y, ~x, 16'h0000, 16'hffff};
        mem.fillPattern();
        pc = 12'd0;
        for (int i = 0; i < 6; i++) begin
            mem.loadWord(pc, addrWord(cpuPkg::OP_LDX, 12'd100));
            mem.loadWord(pc + 12'd1, addrWord(cpuPkg::OP_LDY, 12'd101));
            mem.loadWord(pc + 12'd2, aluWord(fns[i], 1'b1, 1'b0, 1'b0));
            mem.loadWord(pc + 12'd3, addrWord(cpuPkg::OP_OUT, 12'd0));
            pc = pc + 12'd4;
        end
        mem.loadWord(pc, addrWord(cpuPkg::OP_HALT, 12'd0));
        mem.loadWord(12'd100, x);
        mem.loadWord(12'd101, y);
        runProgram(4'd3);
        checkCount(6);
        for (int i = 0; i < 6 && i < outQ.size(); i++) checkWord("outData", outQ[i], exp[i]);
        report("alu functions", e0);
    endtask

    // flags come from an add of x and y, then the jump rule picks a path
    task automatic jumpTest(input string name, input logic [3:0] op,
                            input cpuPkg::word_t x, input cpuPkg::word_t y);
        logic [16:0] sum;
        logic        c;
        logic        z;
        logic        lt;
        logic        taken;
        int          e0;
        e0 = errors;
        sum = {1'b0, x} + {1'b0, y};
        c = sum[16];
        z = sum[15:0] == 16'd0;
        lt = sum[15];
        case (op)
            cpuPkg::OP_JC: taken = c;
            cpuPkg::OP_JZ: taken = z;
            cpuPkg::OP_JGT: taken = !z && !lt;
            default: taken = lt;
        endcase
        mem.fillPattern();
        mem.loadWord(12'd0, addrWord(cpuPkg::OP_LDX, 12'd100));
        mem.loadWord(12'd1, addrWord(cpuPkg::OP_LDY, 12'd101));
        mem.loadWord(12'd2, aluWord(6'b000010, 1'b1, 1'b0, 1'b0));
        mem.loadWord(12'd3, addrWord(op, 12'd8));
        mem.loadWord(12'd4, addrWord(cpuPkg::OP_LDX, 12'd102));
        mem.loadWord(12'd5, addrWord(cpuPkg::OP_OUT, 12'd0));
        mem.loadWord(12'd6, addrWord(cpuPkg::OP_HALT, 12'd0));
        mem.loadWord(12'd8, addrWord(cpuPkg::OP_LDX, 12'd103));
        mem.loadWord(12'd9, addrWord(cpuPkg::OP_OUT, 12'd0));
        mem.loadWord(12'd10, addrWord(cpuPkg::OP_HALT, 12'd0));
        mem.loadWord(12'd100, x);
        mem.loadWord(12'd101, y);
        mem.loadWord(12'd102, 16'h1111);
        mem.loadWord(12'd103, 16'h2222);
        runProgram(4'd3);
        checkCount(1);
        if (outQ.size() > 0) checkWord("outData", outQ[0], taken ? 16'h2222 : 16'h1111);
        report(name, e0);
    endtask

    task automatic carryTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        int          e0;
        e0 = errors;
        a = $urandom;
        b = $urandom;
        s = a + b;
        mem.fillPattern();
        mem.loadWord(12'd0, addrWord(cpuPkg::OP_LDX, 12'd100));
        mem.loadWord(12'd1, addrWord(cpuPkg::OP_LDY, 12'd101));
        mem.loadWord(12'd2, aluWord(6'b000010, 1'b1, 1'b0, 1'b0));
        mem.loadWord(12'd3, addrWord(cpuPkg::OP_OUT, 12'd0));
        mem.loadWord(12'd4, addrWord(cpuPkg::OP_LDX, 12'd102));
        mem.loadWord(12'd5, addrWord(cpuPkg::OP_LDY, 12'd103));
        mem.loadWord(12'd6, aluWord(6'b000010, 1'b1, 1'b0, 1'b1));
        mem.loadWord(12'd7, addrWord(cpuPkg::OP_OUT, 12'd0));
        mem.loadWord(12'd8, addrWord(cpuPkg::OP_HALT, 12'd0));
        mem.loadWord(12'd100, a[15:0]);
        mem.loadWord(12'd101, b[15:0]);
        mem.loadWord(12'd102, a[31:16]);
        mem.loadWord(12'd103, b[31:16]);
        runProgram(4'd3);
        checkCount(2);
        if (outQ.size() == 2) begin
            checkWord("outData low", outQ[0], s[15:0]);
            checkWord("outData high", outQ[1], s[31:16]);
        end
        report("carry chain", e0);
    endtask

    task automatic storeTest();
        cpuPkg::word_t v;
        int            e0;
        e0 = errors;
        v = 16'($urandom);
        mem.fillPattern();
        mem.loadWord(12'd0, addrWord(cpuPkg::OP_LDX, 12'd100));
        mem.loadWord(12'd1, addrWord(cpuPkg::OP_STX, 12'd200));
        mem.loadWord(12'd2, addrWord(cpuPkg::OP_HALT, 12'd0));
        mem.loadWord(12'd100, v);
        runProgram(4'(MAX_WAIT));
        checkWord("mem[200]", mem.peekWord(12'd200), v);
        checkFlagBit("halted", halted, 1'b1);
        repeat (20) begin
            @(posedge clk);
            checkFlagBit("wbStb", wbStb, 1'b0);   // no fetch after halt
        end
        report("store under back-pressure", e0);
    endtask

    initial begin
        void'($urandom(32'hb1cf_6b36));
        resetTest();
        aluTest();
        jumpTest("jc taken", cpuPkg::OP_JC, 16'hffff, 16'h0002);
        jumpTest("jc not taken", cpuPkg::OP_JC, 16'h0001, 16'h0001);
        jumpTest("jz taken", cpuPkg::OP_JZ, 16'h0000, 16'h0000);
        jumpTest("jz not taken", cpuPkg::OP_JZ, 16'h0001, 16'h0001);
        jumpTest("jgt taken", cpuPkg::OP_JGT, 16'h0001, 16'h0001);
        jumpTest("jgt not taken", cpuPkg::OP_JGT, 16'h8000, 16'h0000);
        jumpTest("jlt taken", cpuPkg::OP_JLT, 16'h8000, 16'h0000);
        jumpTest("jlt not taken", cpuPkg::OP_JLT, 16'h0001, 16'h0001);
        carryTest();
        storeTest();
        $display("tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/wbMemModel.sv
`default_nettype none

module wbMemModel (
    input  logic          clk,
    input  logic          wbCyc,
    input  logic          wbStb,
    input  logic          wbWe,
    input  cpuPkg::addr_t wbAdr,
    input  cpuPkg::word_t wbDatW,
    output cpuPkg::word_t wbDatR,
    output logic          wbAck,
    input  logic [3:0]    maxWait
);

    cpuPkg::word_t store [cpuPkg::MEM_WORDS];
    logic [3:0]    waitLeft;

    initial begin
        wbAck <= 1'b0;
        wbDatR <= '0;
        waitLeft <= 4'd0;
    end

    // ack after waitLeft stalled cycles, then draw new wait states
    always @(posedge clk) begin
        wbAck <= 1'b0;
        if (wbCyc && wbStb && !wbAck) begin
            if (waitLeft != 4'd0) begin
                waitLeft <= waitLeft - 4'd1;
            end else begin
                wbAck <= 1'b1;
                if (wbWe) store[wbAdr] = wbDatW;
                wbDatR <= store[wbAdr];
                waitLeft <= 4'($urandom % (32'(maxWait) + 32'd1));
            end
        end
    end

    task automatic fillPattern();
        for (int i = 0; i < cpuPkg::MEM_WORDS; i++) begin
            store[i] = 16'(i * 40503) ^ 16'h5a5a;  // odd multiplier keeps words distinct
        end
    endtask

    task automatic loadWord(input cpuPkg::addr_t addr, input cpuPkg::word_t data);
        store[addr] = data;
    endtask

    function automatic cpuPkg::word_t peekWord(input cpuPkg::addr_t addr);
        return store[addr];
    endfunction

endmodule

`default_nettype wire

// File: verilog/cpu.sv
`default_nettype none

module cpu (
    input  logic          clk,
    input  logic          reset,
    output logic          wbCyc,
    output logic          wbStb,
    output logic          wbWe,
    output cpuPkg::addr_t wbAdr,
    output cpuPkg::word_t wbDatOut,
    input  cpuPkg::word_t wbDatIn,
    input  logic          wbAck,
    output cpuPkg::word_t outData,
    output logic          outValid,
    output logic          halted
);

    cpuPkg::microOp_t uop;
    cpuPkg::addr_t    target;
    cpuPkg::addr_t    pc;
    cpuPkg::word_t    xVal;
    cpuPkg::word_t    yVal;
    cpuPkg::word_t    result;
    cpuPkg::word_t    rdata;
    cpuPkg::flags_t   flags;
    cpuPkg::flags_t   newFlags;
    logic             busDone;

    microSequencer sequencer (
        .clk     (clk),
        .reset   (reset),
        .busDone (busDone),
        .rdata   (rdata),
        .flags   (flags),
        .uop     (uop),
        .target  (target)
    );

    aluExecute alu (
        .xVal     (xVal),
        .yVal     (yVal),
        .fn       (uop.aluFn),
        .carryEn  (uop.carryEn),
        .flags    (flags),
        .result   (result),
        .newFlags (newFlags)
    );

    writeBack regs (
        .clk      (clk),
        .reset    (reset),
        .busDone  (busDone),
        .uop      (uop),
        .target   (target),
        .result   (result),
        .rdata    (rdata),
        .newFlags (newFlags),
        .pc       (pc),
        .xVal     (xVal),
        .yVal     (yVal),
        .flags    (flags),
        .outData  (outData),
        .outValid (outValid),
        .halted   (halted)
    );

    wbMaster bus (
        .clk      (clk),
        .reset    (reset),
        .uop      (uop),
        .pc       (pc),
        .target   (target),
        .xVal     (xVal),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatOut (wbDatOut),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck),
        .busDone  (busDone),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

// File: verilog/wbMaster.sv
`default_nettype none

module wbMaster (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::microOp_t uop,
    input  cpuPkg::addr_t    pc,
    input  cpuPkg::addr_t    target,
    input  cpuPkg::word_t    xVal,
    output logic             wbCyc,
    output logic             wbStb,
    output logic             wbWe,
    output cpuPkg::addr_t    wbAdr,
    output cpuPkg::word_t    wbDatOut,
    input  cpuPkg::word_t    wbDatIn,
    input  logic             wbAck,
    output logic             busDone,
    output cpuPkg::word_t    rdata
);

    logic request;

    assign request = uop.busRead | uop.busWrite;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe <= 1'b0;
        end else if (wbStb) begin
            if (wbAck) begin    // transfer done, drop the cycle
                wbCyc <= 1'b0;
                wbStb <= 1'b0;
                wbWe <= 1'b0;
            end
        end else if (request) begin
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe <= uop.busWrite;
        end
    end

    // address and data are captured once per transfer
    always_ff @(posedge clk) begin
        if (!wbStb && request) begin
            wbAdr <= uop.useTarget ? target : pc;
            wbDatOut <= xVal;
        end
    end

    assign busDone = wbStb & wbAck;
    assign rdata = wbDatIn;

    assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc);

    assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && wbStb);

endmodule

`default_nettype wire

// File: verilog/writeBack.sv
`default_nettype none

module writeBack (
    input  logic             clk,
    input  logic             reset,
    input  logic             busDone,
    input  cpuPkg::microOp_t uop,
    input  cpuPkg::addr_t    target,
    input  cpuPkg::word_t    result,
    input  cpuPkg::word_t    rdata,
    input  cpuPkg::flags_t   newFlags,
    output cpuPkg::addr_t    pc,
    output cpuPkg::word_t    xVal,
    output cpuPkg::word_t    yVal,
    output cpuPkg::flags_t   flags,
    output cpuPkg::word_t    outData,
    output logic             outValid,
    output logic             halted
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (uop.jump) begin
            pc <= target;
        end else if (uop.incPc && busDone) begin
            pc <= pc + 12'd1;   // wraps at the top of memory
        end
    end

    // loads take rdata on the ack, ALU writes land right away
    always_ff @(posedge clk) begin
        if (reset) begin
            xVal <= '0;
        end else if (uop.loadX) begin
            if (!uop.busRead) begin
                xVal <= result;
            end else if (busDone) begin
                xVal <= rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            yVal <= '0;
        end else if (uop.loadY) begin
            if (!uop.busRead) begin
                yVal <= result;
            end else if (busDone) begin
                yVal <= rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (uop.loadFlags) begin
            flags <= newFlags;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            halted <= 1'b0;
        end else begin
            outValid <= uop.outStrobe;  // one cycle per OUT
            if (uop.halt) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (uop.outStrobe) begin
            outData <= xVal;
        end
    end

    // once halted nothing moves pc again
    assert property (@(posedge clk) disable iff (reset)
        halted |=> $stable(pc) && halted);

endmodule

`default_nettype wire

// File: verilog/aluExecute.sv
`default_nettype none

module aluExecute (
    input  cpuPkg::word_t  xVal,
    input  cpuPkg::word_t  yVal,
    input  cpuPkg::aluFn_t fn,
    input  logic           carryEn,
    input  cpuPkg::flags_t flags,
    output cpuPkg::word_t  result,
    output cpuPkg::flags_t newFlags
);

    cpuPkg::word_t xOp;
    cpuPkg::word_t yOp;
    cpuPkg::word_t sum;
    cpuPkg::word_t pre;
    logic          carryIn;
    logic          carryOut;

    always_comb begin
        carryIn = flags.carry & carryEn;    // chains multiword adds

        // zero first, then invert
        xOp = fn.zeroX ? '0 : xVal;
        if (fn.negX) xOp = ~xOp;
        yOp = fn.zeroY ? '0 : yVal;
        if (fn.negY) yOp = ~yOp;

        {carryOut, sum} = {1'b0, xOp} + {1'b0, yOp} + {16'd0, carryIn};
        pre = fn.addSel ? sum : (xOp & yOp);
        result = fn.negOut ? ~pre : pre;

        newFlags.carry = fn.addSel & carryOut;
        newFlags.zero = result == '0;
        newFlags.less = result[15];
    end

endmodule

`default_nettype wire

// File: verilog/microSequencer.sv
`default_nettype none

module microSequencer (
    input  logic             clk,
    input  logic             reset,
    input  logic             busDone,
    input  cpuPkg::word_t    rdata,
    input  cpuPkg::flags_t   flags,
    output cpuPkg::microOp_t uop,
    output cpuPkg::addr_t    target
);

    cpuPkg::instr_t    ir;
    cpuPkg::jumpCond_t cond;
    logic              tState;      // 0 fetch, 1 execute
    logic              condHolds;
    logic              execDone;

    assign target = ir.addrView.target;

    always_ff @(posedge clk) begin
        if (uop.loadIr && busDone) begin
            ir <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tState <= 1'b0;
        end else if (!tState) begin
            if (busDone) tState <= 1'b1;
        end else if (execDone) begin
            tState <= 1'b0;
        end
    end

    // which flags a jump opcode looks at
    always_comb begin
        cond = '0;
        case (ir.addrView.opcode)
            cpuPkg::OP_JMP: cond = '1;
            cpuPkg::OP_JC:  cond.onCarry = 1'b1;
            cpuPkg::OP_JZ:  cond.onZero = 1'b1;
            cpuPkg::OP_JGT: cond.onGreater = 1'b1;
            cpuPkg::OP_JLT: cond.onLess = 1'b1;
            default:        cond = '0;
        endcase
    end

    assign condHolds = (cond.onCarry & flags.carry)
                     | (cond.onZero & flags.zero)
                     | (cond.onLess & flags.less)
                     | (cond.onGreater & ~flags.zero & ~flags.less);

    always_comb begin
        uop = '0;
        execDone = 1'b0;
        if (!tState) begin
            uop.busRead = 1'b1;
            uop.loadIr = 1'b1;
            uop.incPc = 1'b1;
        end else begin
            execDone = 1'b1;    // most instructions take one cycle
            case (ir.aluView.opcode)
                cpuPkg::OP_ALU: begin
                    uop.aluFn = ir.aluView.fn;
                    uop.carryEn = ir.aluView.carryEn;
                    uop.loadX = ir.aluView.destX;
                    uop.loadY = ir.aluView.destY;
                    uop.loadFlags = 1'b1;
                end
                cpuPkg::OP_LDX, cpuPkg::OP_LDY: begin
                    uop.busRead = 1'b1;
                    uop.useTarget = 1'b1;
                    uop.loadX = ir.addrView.opcode == cpuPkg::OP_LDX;
                    uop.loadY = ir.addrView.opcode == cpuPkg::OP_LDY;
                    execDone = busDone;
                end
                cpuPkg::OP_STX: begin
                    uop.busWrite = 1'b1;
                    uop.useTarget = 1'b1;
                    execDone = busDone;
                end
                cpuPkg::OP_JMP, cpuPkg::OP_JC, cpuPkg::OP_JZ,
                cpuPkg::OP_JGT, cpuPkg::OP_JLT: begin
                    uop.jump = condHolds;
                end
                cpuPkg::OP_OUT: uop.outStrobe = 1'b1;
                cpuPkg::OP_HALT: begin
                    uop.halt = 1'b1;
                    execDone = 1'b0;    // parked here for good
                end
                default: ;
            endcase
        end
    end

    // IR holds its instruction through execute
    assert property (@(posedge clk) disable iff (reset)
        tState |=> $stable(ir));

    // an ack only comes back for a requested transfer
    assert property (@(posedge clk) disable iff (reset)
        busDone |-> uop.busRead || uop.busWrite);

endmodule

`default_nettype wire

// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int MEM_WORDS = 4096;

    typedef logic [15:0] word_t;
    typedef logic [11:0] addr_t;

    // opcodes live in the top nibble of every instruction
    localparam logic [3:0] OP_ALU  = 4'h0;
    localparam logic [3:0] OP_LDX  = 4'h1;
    localparam logic [3:0] OP_LDY  = 4'h2;
    localparam logic [3:0] OP_STX  = 4'h3;
    localparam logic [3:0] OP_JMP  = 4'h4;
    localparam logic [3:0] OP_JC   = 4'h5;
    localparam logic [3:0] OP_JZ   = 4'h6;
    localparam logic [3:0] OP_JGT  = 4'h7;
    localparam logic [3:0] OP_JLT  = 4'h8;
    localparam logic [3:0] OP_OUT  = 4'h9;
    localparam logic [3:0] OP_HALT = 4'hf;

    typedef struct packed {
        logic zeroX;
        logic negX;
        logic zeroY;
        logic negY;
        logic addSel;   // add when set, and otherwise
        logic negOut;
    } aluFn_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic less;     // sign of the last result
    } flags_t;

    // all four set means always taken
    typedef struct packed {
        logic onCarry;
        logic onZero;
        logic onGreater;
        logic onLess;
    } jumpCond_t;

    typedef struct packed {
        logic [3:0] opcode;
        aluFn_t     fn;
        logic       destX;
        logic       destY;
        logic       carryEn;
        logic [2:0] spare;
    } aluView_t;

    typedef struct packed {
        logic [3:0] opcode;
        addr_t      target;
    } addrView_t;

    typedef union packed {
        aluView_t  aluView;
        addrView_t addrView;
    } instr_t;

    typedef struct packed {
        logic   busRead;
        logic   busWrite;
        logic   useTarget;  // bus address from the instruction, not pc
        logic   loadIr;
        logic   incPc;
        logic   loadX;
        logic   loadY;
        logic   loadFlags;
        aluFn_t aluFn;
        logic   carryEn;
        logic   jump;       // already qualified by the flags
        logic   outStrobe;
        logic   halt;
    } microOp_t;

endpackage

`default_nettype wire
